/* filelist.f */
hw/pq_entry_pkg.sv
hw/pq_cmd_pkg.sv
hw/pq_slot.sv
hw/pq_storage.sv
hw/pq_arbiter_node.sv
hw/pq_selector.sv
hw/priority_queue.sv
verification/pq_assert.sv
verification/tb_priority_queue.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_priority_queue
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := === PASS ===
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) +verilator+error+limit+100 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/tb_priority_queue.sv */
// Zone request queue testbench: shadow model, directed and random phases
`timescale 1ns/1ps
`default_nettype none

module tb_priority_queue
    import pq_entry_pkg::*;
    import pq_cmd_pkg::*;
();

    localparam int DEPTH        = 4;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_PHASES   = 6;
    localparam int PHASE_CYCLES = 60;

    logic             clk;
    logic             arst_n;
    insert_cmd_t      insert_cmd;
    cancel_cmd_t      cancel_cmd;
    logic             serve;
    wait_t            threshold;
    entry_t           head;
    logic [IDX_W-1:0] head_index;
    logic             queue_full;

    entry_t      model [DEPTH];
    logic [31:0] lcg_state;
    int          check_errors;
    logic        zone_banned;
    zone_t       banned_zone;

    priority_queue #(
        .DEPTH (DEPTH)
    ) dut0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .insert_cmd (insert_cmd),
        .cancel_cmd (cancel_cmd),
        .serve      (serve),
        .threshold  (threshold),
        .head       (head),
        .head_index (head_index),
        .queue_full (queue_full)
    );

    bind priority_queue pq_assert u_assert (
        .clk        (clk),
        .arst_n     (arst_n),
        .insert_cmd (insert_cmd),
        .head       (head),
        .queue_full (queue_full)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog
    initial begin
        #((RESET_CYCLES + NUM_PHASES * PHASE_CYCLES) * CLK_PERIOD);
        $display("Timeout: the test phases did not finish in time");
        $display("=== FAIL ===");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ----------------------------------------
    // Shadow model
    // ----------------------------------------
    // Strictly better, ties stay with the lower slot
    function automatic logic beats(input entry_t x, input entry_t y);
        if (x.boost != y.boost) begin
            return x.boost;
        end
        if (x.prio != y.prio) begin
            return x.prio > y.prio;
        end
        return x.wait_time > y.wait_time;
    endfunction

    function automatic int best_slot();
        int best;
        best = -1;
        for (int i = 0; i < DEPTH; i++) begin
            if (model[i].valid && (best < 0 || beats(model[i], model[best]))) begin
                best = i;
            end
        end
        return best;
    endfunction

    task automatic update_model();
        entry_t updated [DEPTH];
        int     serve_slot;
        int     free_slot;
        serve_slot = best_slot();
        free_slot  = -1;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!model[i].valid) begin
                free_slot = i;
            end
        end
        for (int i = 0; i < DEPTH; i++) begin
            updated[i] = model[i];
            if (model[i].valid && ((serve && i == serve_slot) ||
                (cancel_cmd.enable && model[i].zone == cancel_cmd.zone))) begin
                updated[i] = '0;
            end else if (insert_cmd.insert && i == free_slot) begin
                updated[i] = '{valid: 1'b1, boost: 1'b0, prio: insert_cmd.prio,
                               wait_time: '0, zone: insert_cmd.zone};
            end else if (model[i].valid) begin
                if (model[i].wait_time >= threshold) begin
                    updated[i].boost = 1'b1;
                end
                updated[i].wait_time = model[i].wait_time + 8'd1;
            end
        end
        model = updated;
    endtask

    task automatic report_fail(input string msg);
        check_errors++;
        $display("Fail at %0t: %s", $time, msg);
    endtask

    task automatic check_head();
        int   best;
        logic all_valid;
        best      = best_slot();
        all_valid = 1'b1;
        for (int i = 0; i < DEPTH; i++) begin
            all_valid = all_valid & model[i].valid;
        end
        if (best < 0) begin
            if (head.valid !== 1'b0 || head.boost !== 1'b0) begin
                report_fail("head should be empty");
            end
        end else if (head !== model[best] || head_index !== IDX_W'(best)) begin
            report_fail($sformatf("head %h at %0d, expected %h at %0d",
                                  head, head_index, model[best], best));
        end
        if (queue_full !== all_valid) begin
            report_fail($sformatf("queue_full %b, expected %b", queue_full, all_valid));
        end
        if (zone_banned && head.valid && head.zone == banned_zone) begin
            report_fail($sformatf("head shows removed zone %h", banned_zone));
        end
    endtask

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    // Inputs applied before the call are sampled at the next edge
    task automatic clock_cycle();
        @(posedge clk);
        update_model();
        #2;
        insert_cmd = '0;
        cancel_cmd = '0;
        serve      = 1'b0;
        check_head();
    endtask

    task automatic push(input zone_t zone_id, input prio_t level);
        insert_cmd = '{insert: 1'b1, zone: zone_id, prio: level};
        clock_cycle();
    endtask

    task automatic pop_expect(input zone_t zone_id);
        if (!head.valid || head.zone != zone_id) begin
            report_fail($sformatf("head zone %h, expected %h", head.zone, zone_id));
        end
        serve = 1'b1;
        clock_cycle();
    endtask

    task automatic drain();
        int guard;
        guard = 0;
        while (head.valid && guard < 2 * DEPTH) begin
            serve = 1'b1;
            clock_cycle();
            guard++;
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        logic [31:0] r;
        zone_t       base;
        arst_n       = 1'b0;
        insert_cmd   = '0;
        cancel_cmd   = '0;
        serve        = 1'b0;
        threshold    = 8'hff;
        lcg_state    = 32'hfab07f97;
        check_errors = 0;
        zone_banned  = 1'b0;
        banned_zone  = '0;
        for (int i = 0; i < DEPTH; i++) begin
            model[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        arst_n = 1'b1;
        check_head();

        // Fill, drop a fifth, empty again
        for (int i = 0; i < DEPTH; i++) begin
            r = next_rand();
            push(zone_t'(8'h10 + i), r[1:0]);
        end
        if (!queue_full) begin
            report_fail("queue_full low after four inserts");
        end
        zone_banned = 1'b1;
        banned_zone = 8'h55;
        push(8'h55, 2'd3);
        repeat (DEPTH) begin
            serve = 1'b1;
            clock_cycle();
        end
        if (head.valid) begin
            report_fail("queue not empty after four serves");
        end
        zone_banned = 1'b0;

        // Priority order, then oldest first
        r    = next_rand();
        base = r[15:8] & 8'hfc;
        push(base, 2'd1);
        push(base | 8'd1, 2'd3);
        push(base | 8'd2, 2'd2);
        push(base | 8'd3, 2'd2);
        pop_expect(base | 8'd1);
        pop_expect(base | 8'd2);
        pop_expect(base | 8'd3);
        pop_expect(base);

        // Aged low priority request overtakes
        threshold = 8'd3;
        push(8'h40, 2'd0);
        repeat (4) clock_cycle();
        push(8'h41, 2'd3);
        if (head.zone != 8'h40 || !head.boost) begin
            report_fail("boosted request does not hold the head");
        end
        drain();
        threshold = 8'hff;

        // Cancel of a zone held twice
        push(8'h21, 2'd0);
        push(8'h22, 2'd1);
        push(8'h21, 2'd1);
        push(8'h23, 2'd0);
        cancel_cmd  = '{enable: 1'b1, zone: 8'h21};
        zone_banned = 1'b1;
        banned_zone = 8'h21;
        clock_cycle();
        repeat (2) clock_cycle();
        push(8'h24, 2'd3);
        if (head.zone != 8'h24 || head_index != '0) begin
            report_fail("new request did not refill slot 0");
        end
        drain();
        zone_banned = 1'b0;

        // Random mix of inserts, serves and cancels
        threshold = 8'd6;
        repeat (40) begin
            r = next_rand();
            if (r[1:0] != 2'd0) begin
                insert_cmd = '{insert: 1'b1, zone: {5'd0, r[10:8]}, prio: r[13:12]};
            end
            serve = r[3];
            if (r[7:4] == 4'd0) begin
                cancel_cmd = '{enable: 1'b1, zone: {5'd0, r[18:16]}};
            end
            clock_cycle();
        end
        drain();

        $display("Errors: %0d check, %0d assertion", check_errors,
                 dut0.u_assert.fail_count);
        if (check_errors == 0 && dut0.u_assert.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/pq_assert.sv */
// Request queue assertions: head and full flag consistency, insert visibility
`timescale 1ns/1ps
`default_nettype none

module pq_assert
    import pq_entry_pkg::*;
    import pq_cmd_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  insert_cmd_t insert_cmd,
    input  entry_t      head,
    input  logic        queue_full
);

    // Failures seen so far, read by the testbench at the end
    int unsigned fail_count = 0;

    // A full queue always presents a head
    full_has_head: assert property (@(posedge clk) disable iff (!arst_n)
        !head.valid |-> !queue_full)
    else begin
        $error("queue_full is high while head.valid is low");
        fail_count++;
    end

    // Boost only on a real request
    boost_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
        head.boost |-> head.valid)
    else begin
        $error("head.boost is high while head.valid is low");
        fail_count++;
    end

    // Accepted insert shows up one cycle later
    insert_visible: assert property (@(posedge clk) disable iff (!arst_n)
        (insert_cmd.insert && !queue_full) |=> head.valid)
    else begin
        $error("insert into a non-full queue left head.valid low");
        fail_count++;
    end

endmodule

`default_nettype wire

/* hw/priority_queue.sv */
// Zone request queue: storage slots feeding a tournament selector for the head
`timescale 1ns/1ps
`default_nettype none

module priority_queue
    import pq_entry_pkg::*;
    import pq_cmd_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             arst_n,
    input  insert_cmd_t      insert_cmd,
    input  cancel_cmd_t      cancel_cmd,
    input  logic             serve,
    input  wait_t            threshold,
    output entry_t           head,
    output logic [IDX_W-1:0] head_index,
    output logic             queue_full
);

    entry_t entries [DEPTH];
    grant_t grant;

    pq_storage #(
        .DEPTH (DEPTH)
    ) u_storage (
        .clk         (clk),
        .arst_n      (arst_n),
        .insert_cmd  (insert_cmd),
        .cancel_cmd  (cancel_cmd),
        .serve       (serve),
        .serve_index (grant.index[$clog2(DEPTH)-1:0]),
        .threshold   (threshold),
        .entries     (entries),
        .queue_full  (queue_full)
    );

    pq_selector #(
        .DEPTH (DEPTH)
    ) u_selector (
        .entries (entries),
        .grant   (grant)
    );

    // Head is combinational from the slots
    assign head       = grant.entry;
    assign head_index = grant.index;

endmodule

`default_nettype wire

/* hw/pq_selector.sv */
// Request selector: binary tournament tree over all slots, returns best and index
`timescale 1ns/1ps
`default_nettype none

module pq_selector
    import pq_entry_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  entry_t entries [DEPTH],
    output grant_t grant
);

    localparam int SEL_W = $clog2(DEPTH);

    // Heap layout: node n takes 2n+1 on a and 2n+2 on b, leaves from DEPTH-1
    grant_t tree [2*DEPTH-1];

    // Index field of grant_t must hold every slot number
    if (SEL_W > IDX_W) begin : g_width_check
        $error("pq_selector: DEPTH needs more index bits than grant_t carries");
    end

    // ----------------------------------------
    // Leaves tagged with slot number
    // ----------------------------------------
    for (genvar i = 0; i < DEPTH; i++) begin : g_leaf
        assign tree[DEPTH-1+i] = '{entry: entries[i], index: IDX_W'(i)};
    end

    // ----------------------------------------
    // Reduction, lower index on the a side
    // ----------------------------------------
    for (genvar n = 0; n < DEPTH-1; n++) begin : g_node
        pq_arbiter_node u_node (
            .a      (tree[2*n+1]),
            .b      (tree[2*n+2]),
            .winner (tree[n])
        );
    end

    assign grant = tree[0];

endmodule

`default_nettype wire

/* hw/pq_arbiter_node.sv */
// Arbiter node: picks the better of two candidate requests with its slot index
`timescale 1ns/1ps
`default_nettype none

module pq_arbiter_node
    import pq_entry_pkg::*;
(
    input  grant_t a,
    input  grant_t b,
    output grant_t winner
);

    logic a_wins;

    always_comb begin
        if (!a.entry.valid) begin
            // Also covers both sides empty, b passes with valid low
            a_wins = 1'b0;
        end else if (!b.entry.valid) begin
            a_wins = 1'b1;
        end else if (a.entry.boost != b.entry.boost) begin
            a_wins = a.entry.boost;
        end else if (a.entry.prio != b.entry.prio) begin
            a_wins = a.entry.prio > b.entry.prio;
        end else begin
            // Equal wait goes to a, the lower slot index
            a_wins = a.entry.wait_time >= b.entry.wait_time;
        end
    end

    // Index rides along with the entry
    assign winner = a_wins ? a : b;

endmodule

`default_nettype wire

/* hw/pq_storage.sv */
// Request storage: slot array with free-slot allocation, serve and cancel clears
`timescale 1ns/1ps
`default_nettype none

module pq_storage
    import pq_entry_pkg::*;
    import pq_cmd_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  insert_cmd_t              insert_cmd,
    input  cancel_cmd_t              cancel_cmd,
    input  logic                     serve,
    input  logic [$clog2(DEPTH)-1:0] serve_index,
    input  wait_t                    threshold,
    output entry_t                   entries [DEPTH],
    output logic                     queue_full
);

    localparam int SEL_W = $clog2(DEPTH);

    logic [DEPTH-1:0] valid_vec;
    logic [DEPTH-1:0] free_vec;
    logic [DEPTH-1:0] write_vec;
    logic [DEPTH-1:0] clear_vec;

    // ----------------------------------------
    // Allocation
    // ----------------------------------------
    assign free_vec = ~valid_vec;

    // Lowest free slot as a one-hot, zero when every slot is taken
    assign write_vec = insert_cmd.insert ? (free_vec & (~free_vec + DEPTH'(1))) : '0;

    assign queue_full = &valid_vec;

    // ----------------------------------------
    // Slots with serve and cancel decode
    // ----------------------------------------
    for (genvar i = 0; i < DEPTH; i++) begin : g_slot
        logic serve_hit;
        logic cancel_hit;

        assign valid_vec[i] = entries[i].valid;

        // Only a valid slot is cleared, so an empty serve never hits a fresh write
        assign serve_hit  = serve && (serve_index == SEL_W'(i)) && entries[i].valid;
        assign cancel_hit = cancel_cmd.enable && entries[i].valid &&
                            (entries[i].zone == cancel_cmd.zone);
        assign clear_vec[i] = serve_hit || cancel_hit;

        pq_slot u_slot (
            .clk       (clk),
            .arst_n    (arst_n),
            .write     (write_vec[i]),
            .zone      (insert_cmd.zone),
            .prio      (insert_cmd.prio),
            .clear     (clear_vec[i]),
            .threshold (threshold),
            .entry     (entries[i])
        );
    end

endmodule

`default_nettype wire

/* hw/pq_slot.sv */
// Request slot: holds one request, ages it and sets a sticky boost flag
`timescale 1ns/1ps
`default_nettype none

module pq_slot
    import pq_entry_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   write,
    input  zone_t  zone,
    input  prio_t  prio,
    input  logic   clear,
    input  wait_t  threshold,
    output entry_t entry
);

    logic  valid_q;
    logic  boost_q;
    wait_t wait_q;
    zone_t zone_q;
    prio_t prio_q;

    // ----------------------------------------
    // Control state and aging
    // ----------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
            boost_q <= 1'b0;
            wait_q  <= '0;
        end else if (clear) begin
            valid_q <= 1'b0;
            boost_q <= 1'b0;
            wait_q  <= '0;
        end else if (write) begin
            valid_q <= 1'b1;
            boost_q <= 1'b0;
            wait_q  <= '0;
        end else if (valid_q) begin
            // Count wraps at 8 bits, boost stays once set
            wait_q <= wait_q + 8'd1;
            if (wait_q >= threshold) begin
                boost_q <= 1'b1;
            end
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (clear) begin
            zone_q <= '0;
            prio_q <= '0;
        end else if (write) begin
            zone_q <= zone;
            prio_q <= prio;
        end
    end

    assign entry = '{valid: valid_q, boost: boost_q, prio: prio_q,
                     wait_time: wait_q, zone: zone_q};

endmodule

`default_nettype wire

/* hw/pq_cmd_pkg.sv */
// Request queue command types: insert and cancel strobes with their fields
`default_nettype none

package pq_cmd_pkg;

    import pq_entry_pkg::*;

    // New request, 11 bits
    typedef struct packed {
        logic  insert;
        zone_t zone;
        prio_t prio;
    } insert_cmd_t;

    // Drop every valid request of one zone, 9 bits
    typedef struct packed {
        logic  enable;
        zone_t zone;
    } cancel_cmd_t;

endpackage

`default_nettype wire

/* hw/pq_entry_pkg.sv */
// Request queue entry types: stored request fields and the selection result
`default_nettype none

package pq_entry_pkg;

    // ----------------------------------------
    // Request fields
    // ----------------------------------------
    typedef logic [7:0] zone_t;
    // Larger value is more urgent
    typedef logic [1:0] prio_t;
    typedef logic [7:0] wait_t;

    // Slot index width for the default four-slot queue
    localparam int IDX_W = 2;

    // One stored request, 20 bits
    typedef struct packed {
        logic  valid;
        logic  boost;
        prio_t prio;
        wait_t wait_time;
        zone_t zone;
    } entry_t;

    // ----------------------------------------
    // Selection result
    // ----------------------------------------
    typedef struct packed {
        entry_t           entry;
        logic [IDX_W-1:0] index;
    } grant_t;

endpackage

`default_nettype wire
